// ==== source/pipe_defs.svh ====
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// ------------------------------
// datapath sizing
// ------------------------------

// integer register width for RV64.
`define XLEN 64

// number of architectural integer registers.
`define REG_COUNT 32

// ------------------------------
// reset state
// ------------------------------

// the PC field of a pipeline register comes out of reset at the boot address.
`define RESET_PC 64'h0000_0000_8000_0000

`endif

// ==== source/pipe_pkg.sv ====
`default_nettype none

`include "pipe_defs.svh"

package pipe_pkg;

  // ------------------------------
  // control codes
  // ------------------------------

  typedef enum logic [4:0] {
    EXE_NOP  = 5'd0,
    EXE_ADD  = 5'd1,
    EXE_SUB  = 5'd2,
    EXE_SLL  = 5'd3,
    EXE_SLT  = 5'd4,
    EXE_SLTU = 5'd5,
    EXE_XOR  = 5'd6,
    EXE_SRL  = 5'd7,
    EXE_SRA  = 5'd8,
    EXE_OR   = 5'd9,
    EXE_AND  = 5'd10,
    EXE_ADDW = 5'd11,
    EXE_SUBW = 5'd12,
    EXE_SLLW = 5'd13,
    EXE_SRLW = 5'd14,
    EXE_SRAW = 5'd15
  } exe_op_t;

  // first name is operand a, second is operand b.
  typedef enum logic [2:0] {
    EXE_SRC_NOP      = 3'd0,
    EXE_SRC_RS_RS    = 3'd1,
    EXE_SRC_RS_IMM   = 3'd2,
    EXE_SRC_ZERO_IMM = 3'd3,
    EXE_SRC_PC_IMM   = 3'd4
  } exe_src_t;

  typedef enum logic [3:0] {
    WB_NOP = 4'd0,
    WB_ALU = 4'd1
  } wb_op_t;

  // ------------------------------
  // stage payloads
  // ------------------------------

  typedef struct packed {
    logic             valid;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] pc;
    exe_op_t          exe_op;
    exe_src_t         exe_src;
    wb_op_t           wb_op;
  } id_exe_t;

  typedef struct packed {
    logic             valid;
    logic [4:0]       rd;
    logic [`XLEN-1:0] result;
    wb_op_t           wb_op;
    logic [`XLEN-1:0] pc;
  } exe_wb_t;

endpackage

`default_nettype wire

// ==== source/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic,
  parameter payload_t reset_value = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     enable,
  input  logic     clear,
  input  logic     in_valid,
  input  payload_t d,
  output logic     valid,
  output payload_t q
);

  logic rst_meta;
  logic rst_sync;

  // ------------------------------
  // reset release
  // ------------------------------

  // reset asserts at once but leaves on a clock edge, two flops later.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rst_meta <= 1'b0;
      rst_sync <= 1'b0;
    end else begin
      rst_meta <= 1'b1;
      rst_sync <= rst_meta;
    end
  end

  // ------------------------------
  // stage register
  // ------------------------------

  always_ff @(posedge clk or negedge rst_sync) begin
    if (!rst_sync) begin
      valid <= 1'b0;
      q     <= reset_value;
    end else if (enable) begin
      // clear only kills the valid bit, the payload still moves.
      valid <= in_valid && !clear;
      q     <= d;
    end
  end

  // a held stage must present the same payload and valid on the next cycle.
  hold_stable: assert property (
    @(posedge clk) disable iff (!rst_sync)
    !enable |=> ($stable(q) && $stable(valid))
  );

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module instr_decoder (
  input  logic               instr_valid,
  input  logic [31:0]        instr,
  output logic [4:0]         rd,
  output logic [4:0]         rs1,
  output logic [4:0]         rs2,
  output logic               rs1_used,
  output logic               rs2_used,
  output logic [`XLEN-1:0]   imm,
  output pipe_pkg::exe_op_t  exe_op,
  output pipe_pkg::exe_src_t exe_src,
  output pipe_pkg::wb_op_t   wb_op,
  output logic               legal
);

  import pipe_pkg::*;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  exe_op_t          op;
  logic             known;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign imm_i  = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u  = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};

  // ------------------------------
  // operation select
  // ------------------------------

  always_comb begin
    op    = EXE_NOP;
    known = 1'b0;
    case (opcode)
      7'b0010011: begin
        known = 1'b1;
        case (funct3)
          3'b000: op = EXE_ADD;
          3'b010: op = EXE_SLT;
          3'b011: op = EXE_SLTU;
          3'b100: op = EXE_XOR;
          3'b110: op = EXE_OR;
          3'b111: op = EXE_AND;
          // RV64 shift immediates take six bits, so funct7 is checked on [31:26].
          3'b001: begin
            op    = EXE_SLL;
            known = (instr[31:26] == 6'b000000);
          end
          default: begin
            op    = instr[30] ? EXE_SRA : EXE_SRL;
            known = (instr[31] == 1'b0) && (instr[29:26] == 4'b0000);
          end
        endcase
      end
      7'b0110011: begin
        known = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: op = EXE_ADD;
          10'b0100000_000: op = EXE_SUB;
          10'b0000000_001: op = EXE_SLL;
          10'b0000000_010: op = EXE_SLT;
          10'b0000000_011: op = EXE_SLTU;
          10'b0000000_100: op = EXE_XOR;
          10'b0000000_101: op = EXE_SRL;
          10'b0100000_101: op = EXE_SRA;
          10'b0000000_110: op = EXE_OR;
          10'b0000000_111: op = EXE_AND;
          default:         known = 1'b0;
        endcase
      end
      7'b0011011: begin
        known = 1'b1;
        case (funct3)
          3'b000: op = EXE_ADDW;
          3'b001: begin
            op    = EXE_SLLW;
            known = (funct7 == 7'b0000000);
          end
          3'b101: begin
            op    = instr[30] ? EXE_SRAW : EXE_SRLW;
            known = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
          default: known = 1'b0;
        endcase
      end
      7'b0111011: begin
        known = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: op = EXE_ADDW;
          10'b0100000_000: op = EXE_SUBW;
          10'b0000000_001: op = EXE_SLLW;
          10'b0000000_101: op = EXE_SRLW;
          10'b0100000_101: op = EXE_SRAW;
          default:         known = 1'b0;
        endcase
      end
      7'b0110111, 7'b0010111: begin
        op    = EXE_ADD;
        known = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // ------------------------------
  // control outputs
  // ------------------------------

  assign legal = instr_valid && known;

  always_comb begin
    exe_op   = EXE_NOP;
    exe_src  = EXE_SRC_NOP;
    wb_op    = WB_NOP;
    imm      = '0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    if (legal) begin
      exe_op = op;
      wb_op  = WB_ALU;
      case (opcode)
        7'b0110011, 7'b0111011: begin
          exe_src  = EXE_SRC_RS_RS;
          rs1_used = 1'b1;
          rs2_used = 1'b1;
        end
        7'b0110111: begin
          exe_src = EXE_SRC_ZERO_IMM;
          imm     = imm_u;
        end
        7'b0010111: begin
          exe_src = EXE_SRC_PC_IMM;
          imm     = imm_u;
        end
        default: begin
          exe_src  = EXE_SRC_RS_IMM;
          imm      = imm_i;
          rs1_used = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data,
  input  logic             we,
  input  logic [4:0]       wr_rd,
  input  logic [`XLEN-1:0] wr_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wr_rd != 5'd0)) begin
      regs[wr_rd] <= wr_data;
    end
  end

  // a write in flight is visible to readers in the same cycle.
  always_comb begin
    if (rs1 == 5'd0) begin
      rs1_data = '0;
    end else if (we && (wr_rd == rs1)) begin
      rs1_data = wr_data;
    end else begin
      rs1_data = regs[rs1];
    end
    if (rs2 == 5'd0) begin
      rs2_data = '0;
    end else if (we && (wr_rd == rs2)) begin
      rs2_data = wr_data;
    end else begin
      rs2_data = regs[rs2];
    end
  end

endmodule

`default_nettype wire

// ==== source/alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module alu_exec (
  input  pipe_pkg::exe_op_t  op,
  input  pipe_pkg::exe_src_t src,
  input  logic [`XLEN-1:0]   rs1_data,
  input  logic [`XLEN-1:0]   rs2_data,
  input  logic [`XLEN-1:0]   imm,
  input  logic [`XLEN-1:0]   pc,
  output logic [`XLEN-1:0]   result
);

  import pipe_pkg::*;

  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [5:0]       shamt;
  logic [4:0]       shamt_w;
  logic [31:0]      word;

  // ------------------------------
  // operand select
  // ------------------------------

  always_comb begin
    case (src)
      EXE_SRC_RS_RS: begin
        a = rs1_data;
        b = rs2_data;
      end
      EXE_SRC_RS_IMM: begin
        a = rs1_data;
        b = imm;
      end
      EXE_SRC_ZERO_IMM: begin
        a = '0;
        b = imm;
      end
      EXE_SRC_PC_IMM: begin
        a = pc;
        b = imm;
      end
      default: begin
        a = '0;
        b = '0;
      end
    endcase
  end

  assign shamt   = b[5:0];
  assign shamt_w = b[4:0];

  // ------------------------------
  // compute
  // ------------------------------

  // word ops build a 32-bit value here and are sign extended below.
  always_comb begin
    case (op)
      EXE_ADDW: word = a[31:0] + b[31:0];
      EXE_SUBW: word = a[31:0] - b[31:0];
      EXE_SLLW: word = a[31:0] << shamt_w;
      EXE_SRLW: word = a[31:0] >> shamt_w;
      EXE_SRAW: word = $signed(a[31:0]) >>> shamt_w;
      default:  word = '0;
    endcase
  end

  always_comb begin
    case (op)
      EXE_ADD:  result = a + b;
      EXE_SUB:  result = a - b;
      EXE_SLL:  result = a << shamt;
      EXE_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      EXE_SLTU: result = {{(`XLEN-1){1'b0}}, a < b};
      EXE_XOR:  result = a ^ b;
      EXE_SRL:  result = a >> shamt;
      EXE_SRA:  result = $signed(a) >>> shamt;
      EXE_OR:   result = a | b;
      EXE_AND:  result = a & b;
      EXE_ADDW, EXE_SUBW, EXE_SLLW, EXE_SRLW, EXE_SRAW:
        result = {{(`XLEN-32){word[31]}}, word};
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/stall_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stall_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  input  logic             rs1_used,
  input  logic             rs2_used,
  input  logic             dec_valid,
  input  logic             ex_valid,
  input  logic [4:0]       ex_rd,
  input  pipe_pkg::wb_op_t ex_wb_op,
  input  logic             flush,
  output logic             stall,
  output logic             id_in_valid,
  output logic             clear
);

  import pipe_pkg::*;

  logic ex_writes;
  logic hazard;
  logic flush_seen;

  // only the ID/EXE producer matters, the register file bypass covers EXE/WB.
  assign ex_writes = ex_valid && (ex_wb_op == WB_ALU) && (ex_rd != 5'd0);
  assign hazard    = ex_writes && ((rs1_used && (rs1 == ex_rd)) ||
                                   (rs2_used && (rs2 == ex_rd)));

  assign stall       = dec_valid && hazard;
  assign id_in_valid = dec_valid && !stall;

  // the extra cycle of clear drains whatever was in ID/EXE into EXE/WB.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      flush_seen <= 1'b0;
    end else begin
      flush_seen <= flush;
    end
  end

  assign clear = flush || flush_seen;

  // the bubble taken under stall removes the producer, so a stall lasts one cycle.
  stall_single_cycle: assert property (
    @(posedge clk) disable iff (!rst)
    stall |=> !stall
  );

endmodule

`default_nettype wire

// ==== source/exe_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module exe_pipe_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             instr_valid,
  input  logic [31:0]      instr,
  input  logic [`XLEN-1:0] pc,
  input  logic             flush,
  output logic             stall,
  output logic             wb_valid,
  output logic [4:0]       wb_rd,
  output logic [`XLEN-1:0] wb_data,
  output logic [`XLEN-1:0] wb_pc
);

  import pipe_pkg::*;

  localparam id_exe_t id_exe_reset = '{
    valid: 1'b0, rd: 5'd0, rs1: 5'd0, rs2: 5'd0,
    rs1_data: '0, rs2_data: '0, imm: '0, pc: `RESET_PC,
    exe_op: EXE_NOP, exe_src: EXE_SRC_NOP, wb_op: WB_NOP
  };

  localparam exe_wb_t exe_wb_reset = '{
    valid: 1'b0, rd: 5'd0, result: '0, wb_op: WB_NOP, pc: `RESET_PC
  };

  logic [4:0]       dec_rd;
  logic [4:0]       dec_rs1;
  logic [4:0]       dec_rs2;
  logic             rs1_used;
  logic             rs2_used;
  logic [`XLEN-1:0] dec_imm;
  exe_op_t          dec_exe_op;
  exe_src_t         dec_exe_src;
  wb_op_t           dec_wb_op;
  logic             legal;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic             id_in_valid;
  logic             clear;
  logic             rf_we;
  id_exe_t          id_exe_d;
  id_exe_t          id_exe_q;
  logic             id_exe_valid;
  exe_wb_t          exe_wb_d;
  exe_wb_t          exe_wb_q;
  logic             exe_wb_valid;
  logic [`XLEN-1:0] alu_result;

  // ------------------------------
  // decode and operand read
  // ------------------------------

  instr_decoder u_decoder (
    .instr_valid(instr_valid), .instr(instr), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2),
    .rs1_used(rs1_used), .rs2_used(rs2_used), .imm(dec_imm), .exe_op(dec_exe_op),
    .exe_src(dec_exe_src), .wb_op(dec_wb_op), .legal(legal)
  );

  reg_file u_reg_file (
    .clk(clk), .rst(rst), .rs1(dec_rs1), .rs2(dec_rs2), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .we(rf_we), .wr_rd(exe_wb_q.rd), .wr_data(exe_wb_q.result)
  );

  stall_ctrl u_stall_ctrl (
    .clk(clk), .rst(rst), .rs1(dec_rs1), .rs2(dec_rs2), .rs1_used(rs1_used),
    .rs2_used(rs2_used), .dec_valid(legal), .ex_valid(id_exe_valid), .ex_rd(id_exe_q.rd),
    .ex_wb_op(id_exe_q.wb_op), .flush(flush), .stall(stall), .id_in_valid(id_in_valid),
    .clear(clear)
  );

  assign id_exe_d = '{
    valid: id_in_valid, rd: dec_rd, rs1: dec_rs1, rs2: dec_rs2,
    rs1_data: rs1_data, rs2_data: rs2_data, imm: dec_imm, pc: pc,
    exe_op: dec_exe_op, exe_src: dec_exe_src, wb_op: dec_wb_op
  };

  // ------------------------------
  // stage registers and execute
  // ------------------------------

  // under stall the ID/EXE stage takes a bubble rather than holding.
  pipe_reg #(.payload_t(id_exe_t), .reset_value(id_exe_reset)) id_exe_reg (
    .clk(clk), .rst(rst), .enable(1'b1), .clear(clear), .in_valid(id_in_valid),
    .d(id_exe_d), .valid(id_exe_valid), .q(id_exe_q)
  );

  alu_exec u_alu_exec (
    .op(id_exe_q.exe_op), .src(id_exe_q.exe_src), .rs1_data(id_exe_q.rs1_data),
    .rs2_data(id_exe_q.rs2_data), .imm(id_exe_q.imm), .pc(id_exe_q.pc), .result(alu_result)
  );

  assign exe_wb_d = '{
    valid: id_exe_valid, rd: id_exe_q.rd, result: alu_result,
    wb_op: id_exe_q.wb_op, pc: id_exe_q.pc
  };

  pipe_reg #(.payload_t(exe_wb_t), .reset_value(exe_wb_reset)) exe_wb_reg (
    .clk(clk), .rst(rst), .enable(1'b1), .clear(clear), .in_valid(id_exe_valid),
    .d(exe_wb_d), .valid(exe_wb_valid), .q(exe_wb_q)
  );

  assign rf_we    = exe_wb_valid && (exe_wb_q.wb_op == WB_ALU);
  assign wb_valid = exe_wb_valid;
  assign wb_rd    = exe_wb_q.rd;
  assign wb_data  = exe_wb_q.result;
  assign wb_pc    = exe_wb_q.pc;

endmodule

`default_nettype wire

// ==== verification/exe_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module exe_pipe_tb;

  localparam logic [6:0] op_imm   = 7'h13;
  localparam logic [6:0] op_reg   = 7'h33;
  localparam logic [6:0] op_imm32 = 7'h1b;
  localparam logic [6:0] op_reg32 = 7'h3b;
  localparam logic [6:0] op_lui   = 7'h37;
  localparam logic [6:0] op_auipc = 7'h17;

  typedef struct {
    logic [4:0]       rd;
    logic [`XLEN-1:0] data;
    logic [`XLEN-1:0] pc;
    int               due;
  } entry_t;

  logic             clk;
  logic             rst;
  logic             instr_valid;
  logic [31:0]      instr;
  logic [`XLEN-1:0] pc;
  logic             flush;
  logic             stall;
  logic             wb_valid;
  logic [4:0]       wb_rd;
  logic [`XLEN-1:0] wb_data;
  logic [`XLEN-1:0] wb_pc;

  logic [`XLEN-1:0] model_regs [32];
  entry_t           expected [$];
  entry_t           seen;
  logic [`XLEN-1:0] next_pc;
  logic [4:0]       prod_rd;
  logic             prod_live;
  int               prod_cycle;
  int               cycle_count = 0;
  int               issued_count = 0;
  int               seed;

  exe_pipe_top dut0 (
    .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
    .flush(flush), .stall(stall), .wb_valid(wb_valid), .wb_rd(wb_rd),
    .wb_data(wb_data), .wb_pc(wb_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // ------------------------------
  // checks
  // ------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_wb(input logic [4:0] exp_rd, input logic [`XLEN-1:0] exp_data,
                          input logic [`XLEN-1:0] exp_pc);
    if (wb_rd !== exp_rd || wb_data !== exp_data || wb_pc !== exp_pc) begin
      abort_run($sformatf("mismatch at %0t: wb rd/data/pc %0d/%h/%h, expected %0d/%h/%h",
                          $time, wb_rd, wb_data, wb_pc, exp_rd, exp_data, exp_pc));
    end
  endtask

  task automatic check_stall(input logic exp_stall);
    if (stall !== exp_stall) begin
      abort_run($sformatf("mismatch at %0t: stall is %b, expected %b", $time, stall, exp_stall));
    end
  endtask

  // every writeback must match the oldest prediction, on the cycle it is due.
  always @(negedge clk) begin
    if (rst) begin
      if (wb_valid) begin
        if (expected.size() == 0) begin
          abort_run($sformatf("unexpected writeback to x%0d at %0t", wb_rd, $time));
        end else begin
          seen = expected.pop_front();
          if (seen.due != cycle_count) begin
            abort_run($sformatf("mismatch at %0t: writeback for pc %h at cycle %0d, expected %0d",
                                $time, seen.pc, cycle_count, seen.due));
          end
          check_wb(seen.rd, seen.data, seen.pc);
        end
      end else if (expected.size() != 0 && expected[0].due <= cycle_count) begin
        abort_run($sformatf("writeback for pc %h never appeared", expected[0].pc));
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      if (cycle_count > 50 * issued_count + 100) begin
        abort_run("watchdog timeout, the pipeline stopped making progress");
      end
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic source_regs_hit(input logic [31:0] w, input logic [4:0] r);
    logic rs1_read;
    logic rs2_read;
    rs1_read = (w[6:0] == op_imm) || (w[6:0] == op_imm32) ||
               (w[6:0] == op_reg) || (w[6:0] == op_reg32);
    rs2_read = (w[6:0] == op_reg) || (w[6:0] == op_reg32);
    return (rs1_read && (w[19:15] == r)) || (rs2_read && (w[24:20] == r));
  endfunction

  // RV64I result of a supported instruction against the current model registers.
  function automatic logic [`XLEN-1:0] model_result(input logic [31:0] w,
                                                    input logic [`XLEN-1:0] p);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] r;
    logic [`XLEN-1:0] imm_u;
    logic [31:0]      lw;
    logic             is_reg;
    a      = model_regs[w[19:15]];
    is_reg = (w[6:0] == op_reg) || (w[6:0] == op_reg32);
    b      = is_reg ? model_regs[w[24:20]] : {{(`XLEN-12){w[31]}}, w[31:20]};
    imm_u  = {{(`XLEN-32){w[31]}}, w[31:12], 12'b0};
    r      = '0;
    lw     = '0;
    case (w[6:0])
      op_lui:   r = imm_u;
      op_auipc: r = p + imm_u;
      op_imm, op_reg: begin
        case (w[14:12])
          3'd0: r = (is_reg && w[30]) ? a - b : a + b;
          3'd1: r = a << b[5:0];
          3'd2: r = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
          3'd3: r = {{(`XLEN-1){1'b0}}, a < b};
          3'd4: r = a ^ b;
          3'd5: begin
            if (w[30]) r = $signed(a) >>> b[5:0];
            else r = a >> b[5:0];
          end
          3'd6: r = a | b;
          default: r = a & b;
        endcase
      end
      default: begin
        case (w[14:12])
          3'd0: lw = (is_reg && w[30]) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
          3'd1: lw = a[31:0] << b[4:0];
          default: begin
            if (w[30]) lw = $signed(a[31:0]) >>> b[4:0];
            else lw = a[31:0] >> b[4:0];
          end
        endcase
        r = {{(`XLEN-32){lw[31]}}, lw};
      end
    endcase
    return r;
  endfunction

  // ------------------------------
  // drivers
  // ------------------------------

  // presents one instruction and holds it until it is taken.
  task automatic issue(input logic [31:0] word, input logic legal_instr, input logic flushed,
                       output int stalls);
    entry_t e;
    int     exp_stalls;
    instr       = word;
    pc          = next_pc;
    instr_valid = 1'b1;
    issued_count++;
    stalls = 0;
    @(negedge clk);
    // a producer taken on the previous edge still sits in ID/EXE.
    exp_stalls = 0;
    if (legal_instr && prod_live && (prod_cycle == cycle_count - 1) &&
        source_regs_hit(word, prod_rd)) begin
      exp_stalls = 1;
    end
    check_stall(exp_stalls > 0);
    while (stall) begin
      stalls++;
      @(posedge clk);
      #1;
      @(negedge clk);
      check_stall(stalls < exp_stalls);
    end
    prod_live  = legal_instr && !flush && (word[11:7] != 5'd0);
    prod_rd    = word[11:7];
    prod_cycle = cycle_count;
    if (legal_instr && !flushed) begin
      e.rd   = word[11:7];
      e.data = model_result(word, next_pc);
      e.pc   = next_pc;
      e.due  = cycle_count + 2;
      expected.push_back(e);
      if (e.rd != 5'd0) model_regs[e.rd] = e.data;
    end
    next_pc = next_pc + 64'd4;
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int cycles);
    instr_valid = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      check_stall(1'b0);
      @(posedge clk);
      #1;
    end
  endtask

  // builds a random 64-bit value in rd with a chain of dependent instructions.
  task automatic load_random(input logic [4:0] rd);
    logic [31:0] r1;
    logic [31:0] r2;
    int          st;
    r1 = $random(seed);
    r2 = $random(seed);
    issue(u_type(r1[19:0], rd, op_lui), 1'b1, 1'b0, st);
    issue(i_type(r1[31:20], rd, 3'd0, rd, op_imm), 1'b1, 1'b0, st);
    issue(i_type({6'd0, r2[5:0]}, rd, 3'd1, rd, op_imm), 1'b1, 1'b0, st);
    issue(i_type(r2[31:20], rd, 3'd4, rd, op_imm), 1'b1, 1'b0, st);
  endtask

  // ------------------------------
  // tests
  // ------------------------------

  task automatic reset_and_independent();
    int st;
    idle(6);
    issue(i_type(12'h7ff, 5'd0, 3'd0, 5'd1, op_imm), 1'b1, 1'b0, st);
    issue(u_type(20'h80001, 5'd2, op_lui), 1'b1, 1'b0, st);
    issue(u_type(20'h12345, 5'd3, op_auipc), 1'b1, 1'b0, st);
    issue(i_type(12'hffb, 5'd0, 3'd0, 5'd4, op_imm), 1'b1, 1'b0, st);
    issue(u_type(20'hfffff, 5'd5, op_auipc), 1'b1, 1'b0, st);
    idle(4);
  endtask

  task automatic register_ops();
    logic [16:0] ops [15];
    logic [31:0] r;
    int          st;
    ops = '{
      {7'h00, 3'd0, op_reg}, {7'h20, 3'd0, op_reg}, {7'h00, 3'd2, op_reg},
      {7'h00, 3'd3, op_reg}, {7'h00, 3'd4, op_reg}, {7'h00, 3'd6, op_reg},
      {7'h00, 3'd7, op_reg}, {7'h00, 3'd1, op_reg}, {7'h00, 3'd5, op_reg},
      {7'h20, 3'd5, op_reg}, {7'h00, 3'd0, op_reg32}, {7'h20, 3'd0, op_reg32},
      {7'h00, 3'd1, op_reg32}, {7'h00, 3'd5, op_reg32}, {7'h20, 3'd5, op_reg32}
    };
    for (int round = 0; round < 3; round++) begin
      load_random(5'd5);
      load_random(5'd6);
      for (int i = 0; i < 15; i++) begin
        issue(r_type(ops[i][16:10], 5'd6, 5'd5, ops[i][9:7], 5'(7 + i), ops[i][6:0]),
              1'b1, 1'b0, st);
      end
      r = $random(seed);
      issue(i_type({6'b010000, r[5:0]}, 5'd5, 3'd5, 5'd22, op_imm), 1'b1, 1'b0, st);
      issue(i_type(r[19:8], 5'd6, 3'd3, 5'd23, op_imm), 1'b1, 1'b0, st);
      issue(i_type({7'h20, r[24:20]}, 5'd5, 3'd5, 5'd24, op_imm32), 1'b1, 1'b0, st);
      issue(i_type(r[31:20], 5'd6, 3'd0, 5'd25, op_imm32), 1'b1, 1'b0, st);
    end
    idle(4);
  endtask

  task automatic dependent_pairs();
    int st;
    issue(i_type(12'd100, 5'd0, 3'd0, 5'd20, op_imm), 1'b1, 1'b0, st);
    issue(i_type(12'd7, 5'd20, 3'd0, 5'd21, op_imm), 1'b1, 1'b0, st);
    if (st != 1) abort_run($sformatf("rs1 dependency stalled %0d cycles instead of one", st));
    issue(r_type(7'h00, 5'd21, 5'd0, 3'd0, 5'd22, op_reg), 1'b1, 1'b0, st);
    if (st != 1) abort_run($sformatf("rs2 dependency stalled %0d cycles instead of one", st));
    issue(i_type(12'd9, 5'd0, 3'd0, 5'd23, op_imm), 1'b1, 1'b0, st);
    issue(i_type(12'd1, 5'd0, 3'd0, 5'd24, op_imm), 1'b1, 1'b0, st);
    issue(r_type(7'h00, 5'd0, 5'd23, 3'd0, 5'd25, op_reg), 1'b1, 1'b0, st);
    if (st != 0) abort_run($sformatf("distance two dependency stalled %0d cycles", st));
    idle(4);
  endtask

  task automatic x0_and_illegal();
    int st;
    issue(i_type(12'd55, 5'd0, 3'd0, 5'd0, op_imm), 1'b1, 1'b0, st);
    issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd26, op_reg), 1'b1, 1'b0, st);
    issue(i_type(12'd3, 5'd0, 3'd0, 5'd27, op_imm), 1'b1, 1'b0, st);
    // bad funct7 right behind a producer of its sources must not stall.
    issue(r_type(7'h20, 5'd27, 5'd27, 3'd7, 5'd28, op_reg), 1'b0, 1'b0, st);
    issue(32'h0000_3083, 1'b0, 1'b0, st);
    issue(32'h0000_0000, 1'b0, 1'b0, st);
    issue(r_type(7'h00, 5'd27, 5'd28, 3'd0, 5'd26, op_reg), 1'b1, 1'b0, st);
    idle(4);
  endtask

  task automatic flush_in_flight();
    int st;
    issue(i_type(12'd5, 5'd0, 3'd0, 5'd30, op_imm), 1'b1, 1'b0, st);
    issue(i_type(12'd6, 5'd0, 3'd0, 5'd31, op_imm), 1'b1, 1'b0, st);
    idle(2);
    issue(i_type(12'h111, 5'd0, 3'd0, 5'd30, op_imm), 1'b1, 1'b1, st);
    flush = 1'b1;
    issue(i_type(12'h222, 5'd0, 3'd0, 5'd31, op_imm), 1'b1, 1'b1, st);
    flush = 1'b0;
    idle(3);
    issue(r_type(7'h00, 5'd31, 5'd30, 3'd0, 5'd19, op_reg), 1'b1, 1'b0, st);
    idle(4);
  endtask

  initial begin
    seed        = 32'h797f;
    rst         = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    flush       = 1'b0;
    next_pc     = `RESET_PC;
    prod_rd     = 5'd0;
    prod_live   = 1'b0;
    prod_cycle  = -10;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b1;
    reset_and_independent();
    register_ops();
    dependent_pairs();
    x0_and_illegal();
    flush_in_flight();
    idle(6);
    if (expected.size() != 0) begin
      abort_run("writebacks still missing at the end of the run");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/pipe_pkg.sv
source/pipe_reg.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu_exec.sv
source/stall_ctrl.sv
source/exe_pipe_top.sv
verification/exe_pipe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exe_pipe_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the simulator exits with a failing status when the testbench stops on $fatal.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
